// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vga_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/vga_bus_pkg.sv ====
`default_nettype none

package vga_bus_pkg;

  typedef logic [31:0] bus_adr_t;
  typedef logic [31:0] bus_dat_t;
  typedef logic [3:0]  bus_sel_t;
  typedef logic [9:0]  reg_adr_t; // word address on the slave port.

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    bus_sel_t sel;
    reg_adr_t adr;
    bus_dat_t dat;
  } slv_req_t;

  typedef struct packed {
    logic     ack;
    bus_dat_t dat;
  } slv_rsp_t;

  // the master only reads whole words, so we and sel are fixed.
  typedef struct packed {
    logic     cyc;
    logic     stb;
    bus_adr_t adr;
  } mst_req_t;

  typedef struct packed {
    logic     ack;
    bus_dat_t dat;
  } mst_rsp_t;

  // slave address bits 9:8 select the region. Region 1 is unmapped.
  localparam logic [1:0] REG_REGION_PALETTE = 2'd0;
  localparam logic [1:0] REG_REGION_FONT    = 2'd2;
  localparam logic [1:0] REG_REGION_CTRL    = 2'd3;

  localparam logic [7:0] REG_BASE_OFS  = 8'd0;
  localparam logic [7:0] REG_SETUP_OFS = 8'd1;

  localparam bus_adr_t BASE_RESET = 32'hc000_0000;

endpackage

`default_nettype wire

// ==== logic/vga_cfg_regs.sv ====
`default_nettype none

module vga_cfg_regs (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire vga_bus_pkg::slv_req_t slv_req_i,
  output vga_bus_pkg::slv_rsp_t      slv_rsp_o,
  output vga_bus_pkg::bus_adr_t      base_o,
  output vga_video_pkg::video_mode_t mode_o,
  output vga_video_pkg::pal_wr_t     pal_wr_o
);
  import vga_bus_pkg::*;
  import vga_video_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    DONE
  } state_t;

  state_t   state_q;
  bus_adr_t base_q;
  bus_dat_t setup_q;
  bus_dat_t rdata_q;
  logic     strobe;
  logic     ctrl_hit;
  logic     base_hit;
  logic     setup_hit;

  function automatic bus_dat_t merge_bytes(bus_dat_t cur, bus_dat_t wdat, bus_sel_t sel);
    bus_dat_t res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (sel[i])
        res[8*i +: 8] = wdat[8*i +: 8];
    end
    return res;
  endfunction

  assign strobe    = slv_req_i.cyc && slv_req_i.stb && (state_q == IDLE);
  assign ctrl_hit  = (slv_req_i.adr[9:8] == REG_REGION_CTRL);
  assign base_hit  = ctrl_hit && (slv_req_i.adr[7:0] == REG_BASE_OFS);
  assign setup_hit = ctrl_hit && (slv_req_i.adr[7:0] == REG_SETUP_OFS);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      base_q  <= BASE_RESET;
      setup_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (strobe) begin
            // the memory regions take one extra cycle for the palette write.
            case (slv_req_i.adr[9:8])
              REG_REGION_PALETTE, REG_REGION_FONT: state_q <= WRITE;
              default: state_q <= DONE;
            endcase
          end
        end
        WRITE: state_q <= DONE;
        default: state_q <= IDLE;
      endcase

      if (strobe && slv_req_i.we && base_hit)
        base_q <= merge_bytes(base_q, slv_req_i.dat, slv_req_i.sel);
      if (strobe && slv_req_i.we && setup_hit)
        setup_q <= merge_bytes(setup_q, slv_req_i.dat, slv_req_i.sel);
    end
  end

  always_ff @(posedge clk_i) begin
    if (strobe)
      rdata_q <= base_hit ? base_q : (setup_hit ? setup_q : '0);
  end

  assign slv_rsp_o = '{ack: (state_q == DONE), dat: rdata_q};

  assign base_o = base_q;
  assign mode_o = (setup_q[1:0] == 2'd1) ? MODE_DOUBLE : MODE_NORMAL; // 2 and 3 fall back to normal.

  // the host still holds address and data while the machine sits in WRITE.
  assign pal_wr_o = '{
    en:  (state_q == WRITE) && slv_req_i.we && (slv_req_i.adr[9:8] == REG_REGION_PALETTE),
    idx: slv_req_i.adr[7:0],
    rgb: slv_req_i.dat[23:0]
  };

  a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    slv_rsp_o.ack |=> !slv_rsp_o.ack)
    else $error("slave ack held for more than one cycle");

endmodule

`default_nettype wire

// ==== logic/vga_palette.sv ====
`default_nettype none

module vga_palette (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire vga_video_pkg::pal_wr_t  pal_wr_i,
  input  wire vga_video_pkg::pix_idx_t idx_i,
  input  wire                          active_i,
  output vga_video_pkg::rgb_t          rgb_o
);
  import vga_video_pkg::*;

  rgb_t pal_mem [2**$bits(pix_idx_t)];
  logic active_q;

  always_ff @(posedge clk_i) begin
    if (pal_wr_i.en)
      pal_mem[pal_wr_i.idx] <= pal_wr_i.rgb;
  end

  // idx_i trails the coordinate by one cycle, so active is delayed to match.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      rgb_o    <= '0;
    end else begin
      active_q <= active_i;
      rgb_o    <= active_q ? pal_mem[idx_i] : '0; // black during blanking.
    end
  end

endmodule

`default_nettype wire

// ==== logic/vga_pixel_fetch.sv ====
`default_nettype none

module vga_pixel_fetch (
  input  wire                             clk_i,
  input  wire                             rst_i,
  input  wire vga_bus_pkg::bus_adr_t      base_i,
  input  wire vga_video_pkg::video_mode_t mode_i,
  input  wire                             frame_start_i,
  input  wire vga_video_pkg::coord_t      x_i,
  input  wire vga_video_pkg::coord_t      y_i,
  input  wire                             active_i,
  output vga_bus_pkg::mst_req_t           mst_req_o,
  input  wire vga_bus_pkg::mst_rsp_t      mst_rsp_i,
  output vga_video_pkg::pix_idx_t         pix_idx_o
);
  import vga_bus_pkg::*;
  import vga_video_pkg::*;

  video_mode_t mode_q;
  bus_adr_t    row_adr_q;
  bus_adr_t    adr_q;
  logic [7:0]  word_q;
  logic [8:0]  line_q;
  logic        rep_q;
  logic        done_q;
  logic        cyc_q;
  logic        stale_q;
  logic        dbl;
  logic        last_word;
  logic        issue;
  logic        push;
  logic        pop;
  logic [1:0]  lane;
  bus_dat_t    head;

  bus_dat_t           fifo_mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr_q;
  logic [FIFO_AW-1:0] rd_ptr_q;
  logic [FIFO_AW:0]   cnt_q;
  logic [FIFO_AW:0]   cnt_next;

  assign dbl       = (mode_q == MODE_DOUBLE);
  assign last_word = dbl ? (word_q == 8'(LINE_WORDS / 2 - 1)) : (word_q == 8'(LINE_WORDS - 1));

  // an ack that was pending across frame start belongs to the old frame.
  assign push     = mst_rsp_i.ack && !stale_q && !frame_start_i;
  assign pop      = active_i && (dbl ? (x_i[2:0] == 3'd7) : (x_i[1:0] == 2'd3)) && (cnt_q != '0);
  assign cnt_next = cnt_q + (FIFO_AW + 1)'(push) - (FIFO_AW + 1)'(pop);
  assign issue    = !done_q && !frame_start_i && (!cyc_q || mst_rsp_i.ack) &&
                    (cnt_next < FIFO_DEPTH);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      mode_q  <= MODE_NORMAL;
      done_q  <= 1'b1;
      cyc_q   <= 1'b0;
      stale_q <= 1'b0;
      word_q  <= '0;
      line_q  <= '0;
      rep_q   <= 1'b0;
    end else begin
      cyc_q <= issue || (cyc_q && !mst_rsp_i.ack);
      if (frame_start_i) begin
        mode_q  <= mode_i;
        done_q  <= 1'b0;
        stale_q <= cyc_q && !mst_rsp_i.ack;
        word_q  <= '0;
        line_q  <= '0;
        rep_q   <= 1'b0;
      end else begin
        if (mst_rsp_i.ack)
          stale_q <= 1'b0;
        if (issue && last_word) begin
          word_q <= '0;
          line_q <= line_q + 9'd1;
          rep_q  <= dbl && !rep_q; // double mode fetches every row twice.
          if (line_q == 9'(V_ACTIVE - 1))
            done_q <= 1'b1;
        end else if (issue) begin
          word_q <= word_q + 8'd1;
        end
      end
    end
  end

  // the frame base is used word aligned.
  always_ff @(posedge clk_i) begin
    if (frame_start_i)
      row_adr_q <= {base_i[31:2], 2'b00};
    else if (issue && last_word && (!dbl || rep_q))
      row_adr_q <= row_adr_q + (dbl ? bus_adr_t'(H_ACTIVE / 2) : bus_adr_t'(H_ACTIVE));
    if (issue)
      adr_q <= row_adr_q + bus_adr_t'({word_q, 2'b00});
  end

  assign mst_req_o = '{cyc: cyc_q, stb: cyc_q, adr: adr_q};

  always_ff @(posedge clk_i) begin
    if (push)
      fifo_mem[wr_ptr_q] <= mst_rsp_i.dat;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (frame_start_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_next;
    end
  end

  assign head = fifo_mem[rd_ptr_q];
  assign lane = dbl ? x_i[2:1] : x_i[1:0]; // byte 0 sits in bits 7:0.

  always_ff @(posedge clk_i) begin
    pix_idx_o <= head[{lane, 3'b000} +: 8];
  end

  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    active_i |-> (cnt_q != '0))
    else $error("pixel FIFO empty at x=%0d y=%0d", x_i, y_i);

  // the last pixel of the frame consumes exactly the last fetched word.
  a_frame_drained: assert property (@(posedge clk_i) disable iff (rst_i)
    (active_i && (x_i == coord_t'(H_ACTIVE - 1)) && (y_i == coord_t'(V_ACTIVE - 1)))
    |-> (done_q && !cyc_q && (cnt_q == 1)))
    else $error("fetch and display out of step at frame end");

endmodule

`default_nettype wire

// ==== logic/vga_timing.sv ====
`default_nettype none

module vga_timing (
  input  wire                   clk_i,
  input  wire                   rst_i,
  output vga_video_pkg::coord_t x_o,
  output vga_video_pkg::coord_t y_o,
  output logic                  active_o,
  output logic                  frame_start_o,
  output logic                  hs_o,
  output logic                  vs_o,
  output logic                  blank_n_o
);
  import vga_video_pkg::*;

  // both counters run front porch, sync, back porch and then the active area,
  // so the frame counter origin lies in vertical blanking ahead of the picture.
  coord_t h_q;
  coord_t v_q;
  logic   hs_raw;
  logic   vs_raw;

  logic [PIXEL_LATENCY-1:0] hs_pipe;
  logic [PIXEL_LATENCY-1:0] vs_pipe;
  logic [PIXEL_LATENCY-1:0] blank_pipe;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      h_q <= '0;
      v_q <= '0;
    end else if (h_q == coord_t'(H_TOTAL - 1)) begin
      h_q <= '0;
      if (v_q == coord_t'(V_TOTAL - 1))
        v_q <= '0;
      else
        v_q <= v_q + 10'd1;
    end else begin
      h_q <= h_q + 10'd1;
    end
  end

  assign hs_raw = !((h_q >= H_FRONT) && (h_q < H_FRONT + H_SYNC));
  assign vs_raw = !((v_q >= V_FRONT) && (v_q < V_FRONT + V_SYNC));

  assign active_o      = (h_q >= H_BLANK) && (v_q >= V_BLANK);
  assign x_o           = h_q - coord_t'(H_BLANK); // screen position, valid while active.
  assign y_o           = v_q - coord_t'(V_BLANK);
  assign frame_start_o = (h_q == '0) && (v_q == '0);

  // delays the external video signals to line up with the colour pipeline.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      hs_pipe    <= '1;
      vs_pipe    <= '1;
      blank_pipe <= '0;
    end else begin
      hs_pipe    <= {hs_pipe[PIXEL_LATENCY-2:0], hs_raw};
      vs_pipe    <= {vs_pipe[PIXEL_LATENCY-2:0], vs_raw};
      blank_pipe <= {blank_pipe[PIXEL_LATENCY-2:0], active_o};
    end
  end

  assign hs_o      = hs_pipe[PIXEL_LATENCY-1];
  assign vs_o      = vs_pipe[PIXEL_LATENCY-1];
  assign blank_n_o = blank_pipe[PIXEL_LATENCY-1];

  a_vs_line_start: assert property (@(posedge clk_i) disable iff (rst_i)
    $changed(vs_o) |-> (h_q == coord_t'(PIXEL_LATENCY)))
    else $error("vs changed away from line start, h=%0d", h_q);

endmodule

`default_nettype wire

// ==== logic/vga_top.sv ====
`default_nettype none

module vga_top (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire vga_bus_pkg::slv_req_t slv_req_i,
  output vga_bus_pkg::slv_rsp_t      slv_rsp_o,
  output vga_bus_pkg::mst_req_t      mst_req_o,
  input  wire vga_bus_pkg::mst_rsp_t mst_rsp_i,
  output logic                       hs_o,
  output logic                       vs_o,
  output logic                       blank_n_o,
  output vga_video_pkg::rgb_t        rgb_o
);
  import vga_bus_pkg::*;
  import vga_video_pkg::*;

  bus_adr_t    base;
  video_mode_t mode;
  pal_wr_t     pal_wr;
  coord_t      x;
  coord_t      y;
  logic        active;
  logic        frame_start;
  pix_idx_t    pix_idx;

  vga_cfg_regs u_cfg_regs (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .slv_req_i (slv_req_i),
    .slv_rsp_o (slv_rsp_o),
    .base_o    (base),
    .mode_o    (mode),
    .pal_wr_o  (pal_wr)
  );

  vga_timing u_timing (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .x_o           (x),
    .y_o           (y),
    .active_o      (active),
    .frame_start_o (frame_start),
    .hs_o          (hs_o),
    .vs_o          (vs_o),
    .blank_n_o     (blank_n_o)
  );

  vga_pixel_fetch u_pixel_fetch (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .base_i        (base),
    .mode_i        (mode),
    .frame_start_i (frame_start),
    .x_i           (x),
    .y_i           (y),
    .active_i      (active),
    .mst_req_o     (mst_req_o),
    .mst_rsp_i     (mst_rsp_i),
    .pix_idx_o     (pix_idx)
  );

  vga_palette u_palette (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .pal_wr_i (pal_wr),
    .idx_i    (pix_idx),
    .active_i (active),
    .rgb_o    (rgb_o)
  );

endmodule

`default_nettype wire

// ==== logic/vga_video_pkg.sv ====
`default_nettype none

package vga_video_pkg;

  typedef logic [9:0]  coord_t;
  typedef logic [7:0]  pix_idx_t;
  typedef logic [23:0] rgb_t; // red in bits 23:16, blue in bits 7:0.

  typedef enum logic [1:0] {
    MODE_NORMAL = 2'd0,
    MODE_DOUBLE = 2'd1
  } video_mode_t;

  typedef struct packed {
    logic     en;
    pix_idx_t idx;
    rgb_t     rgb;
  } pal_wr_t;

  // 640x480 at 60 Hz, both syncs active low.
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 10;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 33;

  localparam int H_BLANK = H_FRONT + H_SYNC + H_BACK;
  localparam int H_TOTAL = H_BLANK + H_ACTIVE;
  localparam int V_BLANK = V_FRONT + V_SYNC + V_BACK;
  localparam int V_TOTAL = V_BLANK + V_ACTIVE;

  localparam int PIXEL_LATENCY = 2; // cycles from a coordinate to its colour.
  localparam int LINE_WORDS    = H_ACTIVE / 4;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire

// ==== sources.f ====
logic/vga_bus_pkg.sv
logic/vga_video_pkg.sv
logic/vga_cfg_regs.sv
logic/vga_timing.sv
logic/vga_pixel_fetch.sv
logic/vga_palette.sv
logic/vga_top.sv
tb/vga_checker.sv
tb/tb_vga_top.sv

// ==== tb/tb_vga_top.sv ====
`default_nettype none

module tb_vga_top;
  timeunit 1ns;
  timeprecision 1ps;
  import vga_bus_pkg::*;
  import vga_video_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int WAIT_NONE    = 0;
  localparam int WAIT_FRAME   = 1; // start after the next vs fall.
  localparam int WAIT_MID     = 2; // start in the middle of the next frame's picture.
  localparam reg_adr_t BASE_A  = 10'h300;
  localparam reg_adr_t SETUP_A = 10'h301;

  typedef struct packed {
    logic [1:0] wait_kind;
    reg_adr_t   adr;
    logic       we;
    bus_sel_t   sel;
    bus_dat_t   dat;
    bus_dat_t   exp;
  } op_t;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  slv_req_t    slv_req = '0;
  slv_rsp_t    slv_rsp;
  mst_req_t    mst_req;
  mst_rsp_t    mst_rsp = '0;
  bus_dat_t    exp_dat = '0;
  logic        hs;
  logic        vs;
  logic        blank_n;
  rgb_t        rgb;
  int          errors;
  int          frames;
  int          bus_fails = 0;
  int          wait_left = -1;
  logic [31:0] rng = 32'd2828;
  op_t         ops[$];

  always #(CLK_PERIOD / 2) clk = !clk;

  vga_top UUT (
    .clk_i     (clk),
    .rst_i     (rst),
    .slv_req_i (slv_req),
    .slv_rsp_o (slv_rsp),
    .mst_req_o (mst_req),
    .mst_rsp_i (mst_rsp),
    .hs_o      (hs),
    .vs_o      (vs),
    .blank_n_o (blank_n),
    .rgb_o     (rgb)
  );

  vga_checker u_checker (
    .clk_i     (clk),
    .rst_i     (rst),
    .slv_req_i (slv_req),
    .slv_rsp_i (slv_rsp),
    .exp_dat_i (exp_dat),
    .hs_i      (hs),
    .vs_i      (vs),
    .blank_n_i (blank_n),
    .rgb_i     (rgb),
    .errors_o  (errors),
    .frames_o  (frames)
  );

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic bus_dat_t pattern_word(bus_adr_t a);
    bus_dat_t w;
    bus_adr_t b;
    for (int k = 0; k < 4; k++) begin
      b = {a[31:2], 2'b00} + bus_adr_t'(k);
      w[8*k +: 8] = b[7:0] ^ b[15:8];
    end
    return w;
  endfunction

  // memory model, 0 to 2 wait cycles per read.
  always @(negedge clk) begin
    if (rst) begin
      mst_rsp <= '0;
    end else if (mst_rsp.ack) begin
      mst_rsp <= '0;
    end else if (mst_req.cyc && mst_req.stb) begin
      if (wait_left < 0) begin
        rng = xorshift(rng);
        wait_left = int'(rng % 3);
      end
      if (wait_left == 0) begin
        mst_rsp <= '{ack: 1'b1, dat: pattern_word(mst_req.adr)};
        wait_left = -1;
      end else begin
        wait_left--;
      end
    end
  end

  task automatic add_op(int kind, reg_adr_t adr, logic we, bus_sel_t sel, bus_dat_t dat,
                        bus_dat_t exp);
    ops.push_back('{wait_kind: 2'(kind), adr: adr, we: we, sel: sel, dat: dat, exp: exp});
  endtask

  task automatic run_op(int n, op_t op);
    int cycles;
    if (op.wait_kind != WAIT_NONE) begin
      @(negedge vs);
      if (op.wait_kind == WAIT_MID)
        repeat (200 * H_TOTAL) @(negedge clk);
    end
    @(negedge clk);
    slv_req <= '{cyc: 1'b1, stb: 1'b1, we: op.we, sel: op.sel, adr: op.adr, dat: op.dat};
    exp_dat <= op.exp;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!slv_rsp.ack && cycles < 16);
    if (!slv_rsp.ack) begin
      bus_fails++;
      $display("access %0d to address %h never got an ack", n, op.adr);
    end
    slv_req <= '0;
    $display("access %0d: %s %h done after %0d cycles", n, op.we ? "write" : "read", op.adr,
             cycles);
  endtask

  initial begin
    add_op(WAIT_FRAME, BASE_A, 1'b0, 4'hf, '0, 32'hc000_0000);
    add_op(WAIT_NONE, SETUP_A, 1'b0, 4'hf, '0, '0);
    for (int i = 0; i < 256; i++)
      add_op(WAIT_NONE, reg_adr_t'(i), 1'b1, 4'hf,
             {8'h00, (24'(i) * 24'h010101) ^ 24'ha5a5a5}, '0);
    add_op(WAIT_NONE, BASE_A, 1'b1, 4'b0001, 32'h1234_5678, '0);
    add_op(WAIT_NONE, BASE_A, 1'b0, 4'hf, '0, 32'hc000_0078);
    add_op(WAIT_NONE, BASE_A, 1'b1, 4'b1100, 32'h0001_ffff, '0);
    add_op(WAIT_NONE, BASE_A, 1'b1, 4'b0010, 32'h0000_4000, '0);
    add_op(WAIT_NONE, BASE_A, 1'b0, 4'hf, '0, 32'h0001_4078);
    add_op(WAIT_NONE, SETUP_A, 1'b1, 4'b0010, 32'h0000_ff01, '0);
    add_op(WAIT_NONE, SETUP_A, 1'b0, 4'hf, '0, 32'h0000_ff00);
    add_op(WAIT_NONE, SETUP_A, 1'b1, 4'b1110, 32'h0000_0000, '0);
    add_op(WAIT_NONE, SETUP_A, 1'b0, 4'hf, '0, '0);
    add_op(WAIT_NONE, 10'h302, 1'b0, 4'hf, '0, '0);
    add_op(WAIT_NONE, 10'h3ff, 1'b0, 4'hf, '0, '0);
    add_op(WAIT_NONE, 10'h200, 1'b1, 4'hf, 32'hdead_beef, '0); // font region is ignored.
    add_op(WAIT_NONE, 10'h200, 1'b0, 4'hf, '0, '0);
    add_op(WAIT_NONE, 10'h100, 1'b0, 4'hf, '0, '0);
    add_op(WAIT_NONE, 10'h005, 1'b0, 4'hf, '0, '0);
    // written during frame 1, so frame 2 is the first to use them.
    add_op(WAIT_MID, BASE_A, 1'b1, 4'hf, 32'h0002_0000, '0);
    add_op(WAIT_NONE, SETUP_A, 1'b1, 4'b0001, 32'h0000_0001, '0);
    add_op(WAIT_NONE, SETUP_A, 1'b0, 4'hf, '0, 32'h0000_0001);

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
    foreach (ops[n])
      run_op(n, ops[n]);
    wait (frames >= 3);
    @(negedge clk);
    $display("%0d accesses, %0d frames, %0d check errors, %0d bus failures", ops.size(),
             frames, errors, bus_fails);
    if (errors == 0 && bus_fails == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial begin
    int limit;
    #1;
    limit = 3 * FRAME_CYCLES + 2 * (V_FRONT + V_SYNC) * H_TOTAL + 16 * ops.size();
    repeat (limit) @(posedge clk);
    $display("watchdog ran out after %0d cycles with %0d frames seen", limit, frames);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/vga_checker.sv ====
`default_nettype none

module vga_checker (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire vga_bus_pkg::slv_req_t slv_req_i,
  input  wire vga_bus_pkg::slv_rsp_t slv_rsp_i,
  input  wire vga_bus_pkg::bus_dat_t exp_dat_i,
  input  wire                        hs_i,
  input  wire                        vs_i,
  input  wire                        blank_n_i,
  input  wire vga_video_pkg::rgb_t   rgb_i,
  output int                         errors_o,
  output int                         frames_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import vga_bus_pkg::*;
  import vga_video_pkg::*;

  localparam int X0        = H_SYNC + H_BACK; // first active pixel after the hs fall.
  localparam int Y0        = V_SYNC + V_BACK;
  localparam int MAX_PRINT = 20;

  rgb_t     pal [256];
  rgb_t     row_buf [H_ACTIVE];
  rgb_t     prev_rgb;
  bus_dat_t base_m = BASE_RESET;
  bus_dat_t setup_m = '0;
  bus_adr_t fbase = BASE_RESET;
  logic     fdbl = 1'b0;
  logic     hs_q = 1'b1;
  logic     vs_q = 1'b1;
  logic     synced = 1'b0;
  logic     vs_seen = 1'b0;
  logic     exp_act;
  int       hcnt = 0;
  int       line = -1000;
  int       hs_low = 0;
  int       vs_low = 0;
  int       pix_cnt = 0;
  int       acks = 0;
  int       errors = 0;
  int       frames = 0;
  int       x;
  int       y;

  assign errors_o = errors;
  assign frames_o = frames;

  function automatic bus_dat_t apply_sel(bus_dat_t cur, bus_dat_t wdat, bus_sel_t sel);
    bus_dat_t res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (sel[b])
        res[8*b +: 8] = wdat[8*b +: 8];
    end
    return res;
  endfunction

  // memory holds addr[7:0] ^ addr[15:8] in every byte.
  function automatic rgb_t expected_rgb(int px, int py);
    bus_adr_t a;
    if (fdbl)
      a = fbase + bus_adr_t'((py / 2) * (H_ACTIVE / 2) + px / 2);
    else
      a = fbase + bus_adr_t'(py * H_ACTIVE + px);
    return pal[a[7:0] ^ a[15:8]];
  endfunction

  task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
    errors++;
    if (errors <= MAX_PRINT)
      $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic report_text(string msg);
    errors++;
    if (errors <= MAX_PRINT)
      $display("%s at %0t", msg, $time);
  endtask

  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (slv_rsp_i.ack) begin
        if (!(slv_req_i.cyc && slv_req_i.stb))
          report_text("slave ack came without a request");
        acks++;
        if (!slv_req_i.we) begin
          if (slv_rsp_i.dat !== exp_dat_i)
            report_value("slv_rsp.dat", slv_rsp_i.dat, exp_dat_i);
        end else if (slv_req_i.adr[9:8] == REG_REGION_PALETTE) begin
          pal[slv_req_i.adr[7:0]] = slv_req_i.dat[23:0];
        end else if (slv_req_i.adr == {REG_REGION_CTRL, REG_BASE_OFS}) begin
          base_m = apply_sel(base_m, slv_req_i.dat, slv_req_i.sel);
        end else if (slv_req_i.adr == {REG_REGION_CTRL, REG_SETUP_OFS}) begin
          setup_m = apply_sel(setup_m, slv_req_i.dat, slv_req_i.sel);
        end
      end
      if (!slv_req_i.cyc && acks != 0) begin
        if (acks != 1)
          report_text($sformatf("access got %0d ack pulses instead of one", acks));
        acks = 0;
      end

      if (!hs_i)
        hs_low++;
      if (!vs_i)
        vs_low++;
      if (hs_q && !hs_i) begin
        hcnt = 0;
        line = vs_seen ? 0 : line + 1;
        vs_seen = 1'b0;
      end else begin
        hcnt++;
      end
      if (!hs_q && hs_i) begin
        if (hs_low != H_SYNC)
          report_value("hs low width", hs_low, H_SYNC);
        hs_low = 0;
      end
      if (!vs_q && vs_i) begin
        if (vs_low != V_SYNC * H_TOTAL)
          report_value("vs low width", vs_low, V_SYNC * H_TOTAL);
        vs_low = 0;
      end
      if (vs_q && !vs_i) begin
        if (synced) begin
          frames++;
          if (pix_cnt != H_ACTIVE * V_ACTIVE)
            report_value("active pixel count", pix_cnt, H_ACTIVE * V_ACTIVE);
          $display("frame %0d done, %0d active pixels, double %0b", frames, pix_cnt, fdbl);
        end
        pix_cnt = 0;
        fbase   = base_m; // the DUT took this configuration at its own frame start.
        fdbl    = (setup_m[1:0] == 2'd1);
        vs_seen = 1'b1;
        synced  = 1'b1;
      end

      exp_act = synced && (hcnt >= X0) && (hcnt < X0 + H_ACTIVE) &&
                (line >= Y0) && (line < Y0 + V_ACTIVE);
      if (blank_n_i !== exp_act)
        report_value("blank_n", blank_n_i, exp_act);
      if (blank_n_i)
        pix_cnt++;
      if (exp_act) begin
        x = hcnt - X0;
        y = line - Y0;
        if (rgb_i !== expected_rgb(x, y))
          report_value($sformatf("rgb at %0d,%0d", x, y), rgb_i, expected_rgb(x, y));
        if (fdbl && x[0] && rgb_i !== prev_rgb)
          report_text($sformatf("double mode pixel pair differs at %0d,%0d", x, y));
        if (fdbl && y[0] && rgb_i !== row_buf[x])
          report_text($sformatf("double mode line pair differs at %0d,%0d", x, y));
        row_buf[x] = rgb_i;
        prev_rgb   = rgb_i;
      end else if (rgb_i !== '0) begin
        report_value("rgb during blanking", rgb_i, 0);
      end
      hs_q = hs_i;
      vs_q = vs_i;
    end
  end

endmodule

`default_nettype wire
